/* verilog/proc_pkg.sv */
// processor package
// instruction field positions, opcodes, ALU codes, the pipeline vector types
// and the small decode helpers shared by every stage of the core
package proc_pkg;

    typedef logic [31:0] word_t;     // data, address or instruction word
    typedef logic [4:0]  reg_idx_t;  // register number
    typedef logic [4:0]  opcode_t;   // major opcode
    typedef logic [4:0]  alu_op_t;   // R-type ALU function
    typedef logic [4:0]  shamt_t;    // shift amount
    typedef logic [1:0]  fwd_sel_t;  // execute operand source

    // field positions inside an instruction word
    localparam int opcode_hi = 31;
    localparam int opcode_lo = 27;
    localparam int rd_hi     = 26;
    localparam int rd_lo     = 22;
    localparam int rs_hi     = 21;
    localparam int rs_lo     = 17;
    localparam int rt_hi     = 16;
    localparam int rt_lo     = 12;
    localparam int shamt_hi  = 11;
    localparam int shamt_lo  = 7;
    localparam int alu_hi    = 6;
    localparam int alu_lo    = 2;
    localparam int imm_hi    = 16;   // 17-bit immediate, signed
    localparam int imm_lo    = 0;
    localparam int target_hi = 26;   // 27-bit jump target, signed
    localparam int target_lo = 0;

    // major opcodes
    localparam opcode_t op_rtype = 5'b00000;
    localparam opcode_t op_j     = 5'b00001;
    localparam opcode_t op_bne   = 5'b00010;
    localparam opcode_t op_addi  = 5'b00101;
    localparam opcode_t op_blt   = 5'b00110;
    localparam opcode_t op_sw    = 5'b00111;
    localparam opcode_t op_lw    = 5'b01000;

    // R-type ALU codes
    localparam alu_op_t alu_add = 5'd0;
    localparam alu_op_t alu_sub = 5'd1;
    localparam alu_op_t alu_and = 5'd2;
    localparam alu_op_t alu_or  = 5'd3;
    localparam alu_op_t alu_sll = 5'd4;
    localparam alu_op_t alu_sra = 5'd5;

    localparam word_t    nop_instr = 32'h0000_0000;  // add r0, r0, r0
    localparam reg_idx_t zero_reg  = 5'd0;           // hardwired zero

    // forwarding choices for an execute operand
    localparam fwd_sel_t fwd_none = 2'd0;
    localparam fwd_sel_t fwd_mem  = 2'd1;  // memory stage ALU result
    localparam fwd_sel_t fwd_wb   = 2'd2;  // writeback value

    function automatic opcode_t f_opcode(input word_t instr);
        return instr[opcode_hi:opcode_lo];
    endfunction

    function automatic reg_idx_t f_rd(input word_t instr);
        return instr[rd_hi:rd_lo];
    endfunction

    function automatic reg_idx_t f_rs(input word_t instr);
        return instr[rs_hi:rs_lo];
    endfunction

    function automatic reg_idx_t f_rt(input word_t instr);
        return instr[rt_hi:rt_lo];
    endfunction

    function automatic shamt_t f_shamt(input word_t instr);
        return instr[shamt_hi:shamt_lo];
    endfunction

    function automatic alu_op_t f_alu(input word_t instr);
        return instr[alu_hi:alu_lo];
    endfunction

    function automatic word_t f_imm(input word_t instr);
        return {{(31 - imm_hi){instr[imm_hi]}}, instr[imm_hi:imm_lo]};
    endfunction

    function automatic word_t f_target(input word_t instr);
        return {{(31 - target_hi){instr[target_hi]}}, instr[target_hi:target_lo]};
    endfunction

    // port B reads rd for stores and branches, rt otherwise
    function automatic reg_idx_t f_src_b(input word_t instr);
        opcode_t op;
        op = f_opcode(instr);
        if (op == op_sw || op == op_bne || op == op_blt)
            return f_rd(instr);
        return f_rt(instr);
    endfunction

    function automatic logic f_uses_a(input opcode_t op);
        return op != op_j;  // everything but j reads rs
    endfunction

    function automatic logic f_uses_b(input opcode_t op);
        return op == op_rtype || op == op_sw || op == op_bne || op == op_blt;
    endfunction

    function automatic logic f_writes_rd(input opcode_t op);
        return op == op_rtype || op == op_addi || op == op_lw;
    endfunction

endpackage

/* verilog/fetch_stage.sv */
// fetch stage
// program counter with increment, redirect and stall handling,
// plus the fetch/decode latch that carries PC+1 and the fetched word
module fetch_stage import proc_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  stall,        // load-use hold
    input  logic  redirect,     // taken branch or jump in execute
    input  word_t q_imem,
    input  word_t redirect_pc,
    output word_t address_imem,
    output word_t fd_pc,        // PC+1 of the decode instruction
    output word_t fd_instr
);

    word_t pc;
    word_t pc_plus1;

    assign pc_plus1     = pc + 32'd1;  // wraps silently
    assign address_imem = pc;          // imem answers in the same cycle

    // redirect beats stall
    always_ff @(posedge clock) begin
        if (reset)
            pc <= '0;
        else if (redirect)
            pc <= redirect_pc;
        else if (!stall)
            pc <= pc_plus1;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fd_instr <= nop_instr;
        end else if (redirect) begin
            fd_instr <= nop_instr;  // wrong-path word dropped
        end else if (!stall) begin
            fd_pc    <= pc_plus1;
            fd_instr <= q_imem;
        end
        // stall: hold both
    end

endmodule

/* verilog/decode_stage.sv */
// decode stage
// picks the register file read ports from the opcode, bypasses the
// writeback value into the read data and fills the decode/execute latch,
// dropping in a bubble on stall or redirect
module decode_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     stall,
    input  logic     redirect,
    input  word_t    fd_pc,
    input  word_t    fd_instr,
    input  word_t    data_readRegA,
    input  word_t    data_readRegB,
    input  logic     wb_write,
    input  reg_idx_t wb_reg,
    input  word_t    wb_value,
    output reg_idx_t ctrl_readRegA,
    output reg_idx_t ctrl_readRegB,
    output word_t    dx_pc,
    output word_t    dx_instr,
    output word_t    dx_a,
    output word_t    dx_b
);

    word_t read_a;
    word_t read_b;
    logic  bypass_a;
    logic  bypass_b;
    logic  bubble;

    // port A always reads rs
    assign ctrl_readRegA = f_rs(fd_instr);
    // port B reads rd for sw, bne, blt
    assign ctrl_readRegB = f_src_b(fd_instr);

    // register file writes at the end of this cycle, so the read is stale
    assign bypass_a = wb_write && (wb_reg == ctrl_readRegA);
    assign bypass_b = wb_write && (wb_reg == ctrl_readRegB);

    assign read_a = bypass_a ? wb_value : data_readRegA;
    assign read_b = bypass_b ? wb_value : data_readRegB;

    // nop pushed forward on redirect or stall
    assign bubble = stall || redirect;

    always_ff @(posedge clock) begin
        if (reset)
            dx_instr <= nop_instr;
        else if (bubble)
            dx_instr <= nop_instr;
        else
            dx_instr <= fd_instr;
    end

    // operand and PC latch
    always_ff @(posedge clock) begin
        dx_pc <= fd_pc;   // PC+1, base for branch targets
        dx_a  <= read_a;  // rs value
        dx_b  <= read_b;  // rt or rd value
    end

endmodule

/* verilog/hazard_unit.sv */
// hazard unit
// forwarding selects for both execute operands and the load-use stall;
// memory-stage results take precedence over writeback, r0 never forwards
module hazard_unit import proc_pkg::*; (
    input  word_t    fd_instr,
    input  word_t    dx_instr,
    input  word_t    xm_instr,
    input  logic     wb_write,
    input  reg_idx_t wb_reg,
    output logic     stall,
    output fwd_sel_t fwd_a_sel,
    output fwd_sel_t fwd_b_sel
);

    opcode_t  fd_op;
    opcode_t  dx_op;
    reg_idx_t xm_rd;
    reg_idx_t dx_rd;
    logic     xm_alu_write;  // memory stage holds an ALU result for rd
    logic     fd_dep_a;
    logic     fd_dep_b;

    assign fd_op = f_opcode(fd_instr);
    assign dx_op = f_opcode(dx_instr);
    assign dx_rd = f_rd(dx_instr);
    assign xm_rd = f_rd(xm_instr);

    // lw in memory stage has only its address here
    assign xm_alu_write = (f_opcode(xm_instr) == op_rtype || f_opcode(xm_instr) == op_addi)
                          && xm_rd != zero_reg;

    function automatic fwd_sel_t pick_src(input logic used, input reg_idx_t src);
        if (!used || src == zero_reg)
            return fwd_none;
        if (xm_alu_write && xm_rd == src)
            return fwd_mem;   // youngest value wins
        if (wb_write && wb_reg == src)
            return fwd_wb;
        return fwd_none;
    endfunction

    assign fwd_a_sel = pick_src(f_uses_a(dx_op), f_rs(dx_instr));
    assign fwd_b_sel = pick_src(f_uses_b(dx_op), f_src_b(dx_instr));

    // load in execute feeding the decode instruction
    assign fd_dep_a = f_uses_a(fd_op) && f_rs(fd_instr) == dx_rd;
    assign fd_dep_b = f_uses_b(fd_op) && f_src_b(fd_instr) == dx_rd;

    assign stall = dx_op == op_lw && dx_rd != zero_reg && (fd_dep_a || fd_dep_b);

endmodule

/* verilog/execute_stage.sv */
// execute stage
// forwarding muxes on both operands, immediate selection, the ALU,
// bne/blt/j resolution with redirect, and the execute/memory latch
module execute_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  word_t    dx_pc,
    input  word_t    dx_instr,
    input  word_t    dx_a,
    input  word_t    dx_b,
    input  fwd_sel_t fwd_a_sel,
    input  fwd_sel_t fwd_b_sel,
    input  word_t    wb_value,
    output logic     redirect,
    output word_t    redirect_pc,
    output word_t    xm_instr,
    output word_t    xm_result,
    output word_t    xm_store_data
);

    opcode_t op;
    alu_op_t alu_code;
    shamt_t  shamt;
    word_t   imm;
    word_t   opnd_a;      // rs after forwarding
    word_t   opnd_b;      // rt or rd after forwarding
    word_t   alu_in_b;
    word_t   alu_out;
    word_t   branch_pc;
    logic    is_ne;
    logic    is_lt;

    assign op    = f_opcode(dx_instr);
    assign shamt = f_shamt(dx_instr);
    assign imm   = f_imm(dx_instr);

    always_comb begin
        case (fwd_a_sel)
            fwd_mem: opnd_a = xm_result;
            fwd_wb:  opnd_a = wb_value;
            default: opnd_a = dx_a;
        endcase
    end

    always_comb begin
        case (fwd_b_sel)
            fwd_mem: opnd_b = xm_result;
            fwd_wb:  opnd_b = wb_value;
            default: opnd_b = dx_b;
        endcase
    end

    // addi, lw, sw use the immediate and add
    assign alu_in_b = (op == op_rtype) ? opnd_b : imm;
    assign alu_code = (op == op_rtype) ? f_alu(dx_instr) : alu_add;

    always_comb begin
        case (alu_code)
            alu_add: alu_out = opnd_a + alu_in_b;
            alu_sub: alu_out = opnd_a - alu_in_b;
            alu_and: alu_out = opnd_a & alu_in_b;
            alu_or:  alu_out = opnd_a | alu_in_b;
            alu_sll: alu_out = opnd_a << shamt;
            alu_sra: alu_out = word_t'($signed(opnd_a) >>> shamt);
            default: alu_out = '0;  // unused codes
        endcase
    end

    // branches compare rd (port B) against rs (port A)
    assign is_ne = opnd_b != opnd_a;
    assign is_lt = $signed(opnd_b) < $signed(opnd_a);

    assign branch_pc = dx_pc + imm;  // dx_pc already PC+1

    assign redirect = (op == op_j)
                   || (op == op_bne && is_ne)
                   || (op == op_blt && is_lt);

    assign redirect_pc = (op == op_j) ? f_target(dx_instr) : branch_pc;

    always_ff @(posedge clock) begin
        if (reset)
            xm_instr <= nop_instr;
        else
            xm_instr <= dx_instr;
    end

    always_ff @(posedge clock) begin
        xm_result     <= alu_out;  // ALU result or memory address
        xm_store_data <= opnd_b;   // rd value for sw
    end

endmodule

/* verilog/memory_writeback.sv */
// memory and writeback stages
// drives the data memory from the execute/memory latch, keeps the
// memory/writeback latch and produces the register file write port,
// which also feeds the forwarding paths and the decode bypass
module memory_writeback import proc_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  word_t    xm_instr,
    input  word_t    xm_result,
    input  word_t    xm_store_data,
    input  word_t    q_dmem,
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    output logic     ctrl_writeEnable,
    output reg_idx_t ctrl_writeReg,
    output word_t    data_writeReg,
    output logic     wb_write,
    output reg_idx_t wb_reg,
    output word_t    wb_value
);

    word_t   mw_instr;
    word_t   mw_result;
    word_t   mw_load;
    opcode_t mw_op;

    // memory access
    assign address_dmem = xm_result;
    assign data         = xm_store_data;
    assign wren         = f_opcode(xm_instr) == op_sw;  // store at next edge

    always_ff @(posedge clock) begin
        if (reset)
            mw_instr <= nop_instr;
        else
            mw_instr <= xm_instr;
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_load   <= q_dmem;  // read word, valid for lw only
    end

    // writeback
    assign mw_op    = f_opcode(mw_instr);
    assign wb_reg   = f_rd(mw_instr);
    assign wb_write = f_writes_rd(mw_op) && wb_reg != zero_reg;  // r0 never written
    assign wb_value = (mw_op == op_lw) ? mw_load : mw_result;

    // register file port is the same writeback triple
    assign ctrl_writeEnable = wb_write;
    assign ctrl_writeReg    = wb_reg;
    assign data_writeReg    = wb_value;

endmodule

/* verilog/processor.sv */
// five-stage pipelined processor core
// fetch, decode, execute, memory and writeback with a hazard unit beside them;
// instruction memory, data memory and register file live outside the core
module processor import proc_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    // instruction memory
    output word_t    address_imem,
    input  word_t    q_imem,
    // data memory
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    input  word_t    q_dmem,
    // register file
    output logic     ctrl_writeEnable,
    output reg_idx_t ctrl_writeReg,
    output reg_idx_t ctrl_readRegA,
    output reg_idx_t ctrl_readRegB,
    output word_t    data_writeReg,
    input  word_t    data_readRegA,
    input  word_t    data_readRegB
);

    word_t    fd_pc;
    word_t    fd_instr;
    word_t    dx_pc;
    word_t    dx_instr;
    word_t    dx_a;
    word_t    dx_b;
    word_t    xm_instr;
    word_t    xm_result;
    word_t    xm_store_data;
    logic     redirect;
    word_t    redirect_pc;
    logic     stall;
    fwd_sel_t fwd_a_sel;
    fwd_sel_t fwd_b_sel;
    logic     wb_write;
    reg_idx_t wb_reg;
    word_t    wb_value;

    fetch_stage i_fetch (
        .clock        (clock),
        .reset        (reset),
        .stall        (stall),
        .redirect     (redirect),
        .q_imem       (q_imem),
        .redirect_pc  (redirect_pc),
        .address_imem (address_imem),
        .fd_pc        (fd_pc),
        .fd_instr     (fd_instr)
    );

    decode_stage i_decode (
        .clock         (clock),
        .reset         (reset),
        .stall         (stall),
        .redirect      (redirect),
        .fd_pc         (fd_pc),
        .fd_instr      (fd_instr),
        .data_readRegA (data_readRegA),
        .data_readRegB (data_readRegB),
        .wb_write      (wb_write),
        .wb_reg        (wb_reg),
        .wb_value      (wb_value),
        .ctrl_readRegA (ctrl_readRegA),
        .ctrl_readRegB (ctrl_readRegB),
        .dx_pc         (dx_pc),
        .dx_instr      (dx_instr),
        .dx_a          (dx_a),
        .dx_b          (dx_b)
    );

    hazard_unit i_hazard (
        .fd_instr  (fd_instr),
        .dx_instr  (dx_instr),
        .xm_instr  (xm_instr),
        .wb_write  (wb_write),
        .wb_reg    (wb_reg),
        .stall     (stall),
        .fwd_a_sel (fwd_a_sel),
        .fwd_b_sel (fwd_b_sel)
    );

    execute_stage i_execute (
        .clock         (clock),
        .reset         (reset),
        .dx_pc         (dx_pc),
        .dx_instr      (dx_instr),
        .dx_a          (dx_a),
        .dx_b          (dx_b),
        .fwd_a_sel     (fwd_a_sel),
        .fwd_b_sel     (fwd_b_sel),
        .wb_value      (wb_value),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .xm_instr      (xm_instr),
        .xm_result     (xm_result),
        .xm_store_data (xm_store_data)
    );

    memory_writeback i_mem_wb (
        .clock            (clock),
        .reset            (reset),
        .xm_instr         (xm_instr),
        .xm_result        (xm_result),
        .xm_store_data    (xm_store_data),
        .q_dmem           (q_dmem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .data_writeReg    (data_writeReg),
        .wb_write         (wb_write),
        .wb_reg           (wb_reg),
        .wb_value         (wb_value)
    );

endmodule

/* tb/ref_model.svh */
// random program generator and in-order ISA model for the processor testbench
// fills the instruction ROM, then runs the program one instruction at a time
// and queues the register writes and stores that the pipeline must produce
`ifndef ref_model_svh
`define ref_model_svh

localparam int prog_len  = 200;  // random part, nops after it
localparam int rom_words = 256;

word_t    rom [0:255];      // instruction ROM contents
word_t    m_regs [0:31];    // architectural registers
word_t    m_mem [0:255];    // architectural data memory
reg_idx_t exp_wr_reg [$];   // expected writes, program order
word_t    exp_wr_val [$];
word_t    exp_st_addr [$];  // expected stores, program order
word_t    exp_st_data [$];
int       taken_count;

// data RAM start value built from every address bit
function automatic word_t fill_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'h5a, a + 8'h33};
endfunction

function automatic word_t enc_rtype(input reg_idx_t rd, input reg_idx_t rs,
                                    input reg_idx_t rt, input shamt_t sh,
                                    input alu_op_t alu);
    return {op_rtype, rd, rs, rt, sh, alu, 2'b00};
endfunction

function automatic word_t enc_itype(input opcode_t op, input reg_idx_t rd,
                                    input reg_idx_t rs, input logic [16:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic word_t enc_jump(input logic [26:0] target);
    return {op_j, target};  // absolute target
endfunction

function automatic reg_idx_t pick_reg();
    return reg_idx_t'($urandom % 8);  // few registers, many hazards
endfunction

function automatic logic [16:0] small_offset(input int span);
    return 17'($urandom % span);
endfunction

task automatic gen_program();
    int       i;
    int       kind;
    reg_idx_t ld_reg;
    i = 0;
    // r1..r7 seeded first so no store shows up right after reset
    while (i < 7) begin
        rom[i[7:0]] = enc_itype(op_addi, reg_idx_t'(i + 1), zero_reg, 17'($urandom));
        i++;
    end
    while (i < prog_len) begin
        kind = int'($urandom % 16);
        case (kind)
            6, 7:   rom[i[7:0]] = enc_itype(op_addi, pick_reg(), pick_reg(), 17'($urandom));
            8:      rom[i[7:0]] = enc_itype(op_lw, pick_reg(), pick_reg(), small_offset(64));
            9: begin
                // load and a consumer right behind it
                ld_reg = reg_idx_t'(1 + $urandom % 7);
                rom[i[7:0]] = enc_itype(op_lw, ld_reg, pick_reg(), small_offset(64));
                if (i + 1 < prog_len) begin
                    i++;
                    rom[i[7:0]] = enc_rtype(pick_reg(), ld_reg, pick_reg(), 5'd0, alu_add);
                end
            end
            10, 11: rom[i[7:0]] = enc_itype(op_sw, pick_reg(), pick_reg(), small_offset(64));
            12:     rom[i[7:0]] = enc_itype(op_bne, pick_reg(), pick_reg(), small_offset(4));
            13:     rom[i[7:0]] = enc_itype(op_blt, pick_reg(), pick_reg(), small_offset(4));
            14:     rom[i[7:0]] = enc_jump(27'(i + 1 + int'(small_offset(4))));  // forward
            default: rom[i[7:0]] = enc_rtype(pick_reg(), pick_reg(), pick_reg(),
                                             shamt_t'($urandom % 32), alu_op_t'($urandom % 6));
        endcase
        i++;
    end
    for (i = prog_len; i < rom_words; i++)
        rom[i[7:0]] = nop_instr;  // padding
endtask

function automatic void record_write(input reg_idx_t rd, input word_t value);
    if (rd == zero_reg)
        return;  // r0 stays zero
    m_regs[rd] = value;
    exp_wr_reg.push_back(rd);
    exp_wr_val.push_back(value);
endfunction

task automatic run_model();
    word_t    pc;
    word_t    instr;
    word_t    rsv;
    word_t    rtv;
    word_t    rdv;
    word_t    imm;
    word_t    addr;
    word_t    res;
    opcode_t  op;
    reg_idx_t rd;
    shamt_t   sh;
    int       steps;
    for (int r = 0; r < 32; r++)
        m_regs[r[4:0]] = '0;
    for (int a = 0; a < rom_words; a++)
        m_mem[a[7:0]] = fill_word(a[7:0]);
    pc = '0;
    steps = 0;
    taken_count = 0;
    while (pc < word_t'(prog_len) && steps < 1000) begin
        instr = rom[pc[7:0]];
        op    = instr[31:27];
        rd    = instr[26:22];
        rsv   = m_regs[instr[21:17]];
        rtv   = m_regs[instr[16:12]];
        rdv   = m_regs[rd];  // store data and branch operand
        sh    = instr[11:7];
        imm   = {{15{instr[16]}}, instr[16:0]};
        addr  = rsv + imm;
        pc    = pc + 1;      // branches add imm to PC+1
        case (op)
            op_rtype: begin
                case (instr[6:2])
                    alu_add: res = rsv + rtv;
                    alu_sub: res = rsv - rtv;
                    alu_and: res = rsv & rtv;
                    alu_or:  res = rsv | rtv;
                    alu_sll: res = rsv << sh;
                    alu_sra: res = word_t'($signed(rsv) >>> sh);
                    default: res = '0;
                endcase
                record_write(rd, res);
            end
            op_addi: record_write(rd, addr);
            op_lw:   record_write(rd, m_mem[addr[7:0]]);  // low 8 bits select the word
            op_sw: begin
                m_mem[addr[7:0]] = rdv;
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(rdv);
            end
            op_bne: begin
                if (rdv != rsv) begin
                    pc = pc + imm;
                    taken_count++;
                end
            end
            op_blt: begin
                if ($signed(rdv) < $signed(rsv)) begin
                    pc = pc + imm;
                    taken_count++;
                end
            end
            op_j: begin
                pc = {{5{instr[26]}}, instr[26:0]};
                taken_count++;
            end
            default: ;
        endcase
        steps++;
    end
endtask

`endif

/* tb/tb_processor.sv */
// testbench for the five-stage pipelined processor
// instruction ROM, data RAM and register file models around the DUT,
// a random program checked write by write and store by store against
// an in-order model of the ISA, plus a watchdog
module tb_processor import proc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    `include "ref_model.svh"

    localparam int drain_pc        = prog_len + 10;     // fetch well past the program
    localparam int watchdog_cycles = 3 * prog_len + 50;

    logic     clock = 1'b0;
    logic     reset;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_writeEnable;
    reg_idx_t ctrl_writeReg;
    reg_idx_t ctrl_readRegA;
    reg_idx_t ctrl_readRegB;
    word_t    data_writeReg;
    word_t    data_readRegA;
    word_t    data_readRegB;

    word_t ram [0:255];
    word_t regfile [0:31];

    int value_errors = 0;  // wrong register, value, address or data
    int order_errors = 0;  // extra writes or stores, r0 writes
    int reset_errors = 0;  // activity in the reset window
    int end_errors   = 0;  // leftovers and final register file
    int since_reset  = 0;
    int wr_count     = 0;
    int st_count     = 0;

    always #20 clock = ~clock;  // 40 ns period

    processor i_processor (.*);

    // memories answer in the same cycle
    assign q_imem        = (address_imem < 32'd256) ? rom[address_imem[7:0]] : nop_instr;
    assign q_dmem        = ram[address_dmem[7:0]];
    assign data_readRegA = regfile[ctrl_readRegA];
    assign data_readRegB = regfile[ctrl_readRegB];

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 256; i++)
                ram[i[7:0]] <= fill_word(i[7:0]);
            for (int i = 0; i < 32; i++)
                regfile[i[4:0]] <= '0;
        end else begin
            if (wren)
                ram[address_dmem[7:0]] <= data;
            if (ctrl_writeEnable && ctrl_writeReg != zero_reg)
                regfile[ctrl_writeReg] <= data_writeReg;  // r0 kept at zero
        end
    end

    task automatic check_write();
        if (ctrl_writeReg == zero_reg) begin
            $display("register 0 written with %h at %0t", data_writeReg, $time);
            order_errors++;
        end else if (exp_wr_reg.size() == 0) begin
            $display("extra register write r%0d = %h at %0t",
                     ctrl_writeReg, data_writeReg, $time);
            order_errors++;
        end else begin
            if (ctrl_writeReg != exp_wr_reg[0]) begin
                $display("** Error at %0t: ctrl_writeReg expected %0d got %0d",
                         $time, exp_wr_reg[0], ctrl_writeReg);
                value_errors++;
            end
            if (data_writeReg != exp_wr_val[0]) begin
                $display("** Error at %0t: data_writeReg expected %h got %h",
                         $time, exp_wr_val[0], data_writeReg);
                value_errors++;
            end
            void'(exp_wr_reg.pop_front());
            void'(exp_wr_val.pop_front());
            wr_count++;
        end
    endtask

    task automatic check_store();
        if (exp_st_addr.size() == 0) begin
            $display("extra store of %h to %h at %0t", data, address_dmem, $time);
            order_errors++;
        end else begin
            if (address_dmem != exp_st_addr[0]) begin
                $display("** Error at %0t: address_dmem expected %h got %h",
                         $time, exp_st_addr[0], address_dmem);
                value_errors++;
            end
            if (data != exp_st_data[0]) begin
                $display("** Error at %0t: data expected %h got %h", $time, exp_st_data[0], data);
                value_errors++;
            end
            void'(exp_st_addr.pop_front());
            void'(exp_st_data.pop_front());
            st_count++;
        end
    endtask

    task automatic report_counts();
        $display({"errors: %0d value, %0d order, %0d reset window, %0d end of run",
                  " (%0d writes, %0d stores)"},
                 value_errors, order_errors, reset_errors, end_errors, wr_count, st_count);
    endtask

    // outputs sampled mid-cycle before the edge that commits them
    always @(negedge clock) begin
        if (reset || since_reset < 4) begin
            if (ctrl_writeEnable !== 1'b0 || wren !== 1'b0) begin
                $display("write activity in the reset window at %0t: wr_en %b wren %b",
                         $time, ctrl_writeEnable, wren);
                reset_errors++;
            end
            if (!reset)
                since_reset++;
        end else begin
            if (ctrl_writeEnable)
                check_write();
            if (wren)
                check_store();
        end
    end

    initial begin
        reset = 1'b1;
        void'($urandom(32'h9e904619));  // single seed for the run
        gen_program();
        run_model();
        $display("model: %0d register writes, %0d stores, %0d taken branches and jumps",
                 exp_wr_reg.size(), exp_st_addr.size(), taken_count);
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        // targets are all forward so the PC only drifts past the end
        while (address_imem < word_t'(drain_pc))
            @(negedge clock);
        repeat (8) @(negedge clock);  // pipeline empties
        if (exp_wr_reg.size() != 0) begin
            $display("%0d expected register writes never appeared", exp_wr_reg.size());
            end_errors++;
        end
        if (exp_st_addr.size() != 0) begin
            $display("%0d expected stores never appeared", exp_st_addr.size());
            end_errors++;
        end
        for (int r = 0; r < 32; r++) begin
            if (regfile[r[4:0]] != m_regs[r[4:0]]) begin
                $display("** Error at %0t: regfile[%0d] expected %h got %h",
                         $time, r, m_regs[r[4:0]], regfile[r[4:0]]);
                end_errors++;
            end
        end
        report_counts();
        if (value_errors + order_errors + reset_errors + end_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // watchdog at 3 cycles per instruction plus slack
    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles, the program never ran to its end",
                 watchdog_cycles);
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* list.f */
+incdir+tb
verilog/proc_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_writeback.sv
verilog/processor.sv
tb/tb_processor.sv

/* Makefile */
# Verilator build, run and lint for the pipelined processor testbench
# any variable can be overridden on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_processor
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ns
VFLAGS    ?= --timing --timescale $(TIMESCALE)
PASS_TEXT ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass or fail comes from the log, not from the simulator exit code
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
